//--- hw/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

	localparam int I2C_BYTE_W = 8;
	localparam int I2C_STATUS_W = 9;

	typedef logic [I2C_BYTE_W-1:0] i2c_byte_t;
	typedef logic [I2C_STATUS_W-1:0] i2c_status_t;

	localparam i2c_status_t I2C_NO_ERR = 9'h000;
	localparam i2c_status_t I2C_ERR_NO_ADDR_ACK = 9'h001;
	localparam i2c_status_t I2C_ERR_NO_DATA_ACK = 9'h002;
	localparam i2c_status_t I2C_ERR_TX_EMPTY = 9'h004;

	localparam logic I2C_ACK = 1'b0; // ack is sda held low

	typedef enum logic [3:0] {
		ST_IDLE, ST_START, ST_STOP, ST_OUT_ADDR, ST_CHECK_ADDR, ST_IN_DATA,
		ST_CHECK_IN, ST_OUT_DATA, ST_CHECK_OUT, ST_DATA_LOOP, ST_ACK
	} i2c_state_e;

	typedef enum logic [1:0] {
		STREAM_NONE,
		STREAM_ADDR,
		STREAM_RX,
		STREAM_TX
	} i2c_stream_e;

endpackage

`default_nettype wire

//--- hw/i2c_fifo_if.sv
`default_nettype none

interface i2c_fifo_if
	import i2c_pkg::*;
();

	logic push;
	i2c_byte_t push_data;
	logic full;
	logic pop;
	i2c_byte_t pop_data; // head entry, valid while empty is low
	logic empty;

	modport fifo (input push, input push_data, output full,
		input pop, output pop_data, output empty);

	modport writer (output push, output push_data, input full);

	modport reader (output pop, input pop_data, input empty);

endinterface

`default_nettype wire

//--- hw/i2c_scl_timer.sv
`default_nettype none

module i2c_scl_timer #(
	parameter int CLK_DIV = 8
) (
	input  logic clk,
	input  logic rst_n,
	output logic scl,
	output logic scl_delay
);

	localparam int CW = $clog2(CLK_DIV);
	localparam logic [CW-1:0] LAST = CW'(CLK_DIV - 1);

	logic [CW-1:0] half_cnt;
	logic [CW-1:0] dly_cnt;
	logic dly_armed;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			half_cnt <= '0;
			scl <= 1'b1; // idle bus high
		end else if (half_cnt == LAST) begin
			half_cnt <= '0;
			scl <= ~scl;
		end else begin
			half_cnt <= half_cnt + 1'b1;
		end
	end

	// second counter runs half of a half period behind the first,
	// so scl_delay flips in the middle of every scl phase
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dly_cnt <= CW'(CLK_DIV / 2);
			dly_armed <= 1'b0;
			scl_delay <= 1'b1;
		end else begin
			if (half_cnt == LAST) begin
				dly_armed <= 1'b1; // first scl edge seen
			end
			if (dly_cnt == LAST) begin
				dly_cnt <= '0;
				if (dly_armed) begin
					scl_delay <= ~scl_delay;
				end
			end else begin
				dly_cnt <= dly_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/i2c_sync_fifo.sv
`default_nettype none

module i2c_sync_fifo
	import i2c_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
) (
	input  logic     clk,
	input  logic     rst_n,
	i2c_fifo_if.fifo port
);

	localparam int AW = $clog2(FIFO_DEPTH);

	i2c_byte_t mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic do_push;
	logic do_pop;

	assign port.full = (count == (AW + 1)'(FIFO_DEPTH));
	assign port.empty = (count == '0);
	assign port.pop_data = mem[rd_ptr];
	assign do_push = port.push & ~port.full; // push into full fifo is lost
	assign do_pop = port.pop & ~port.empty;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= port.push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/i2c_byte_engine.sv
`default_nettype none

module i2c_byte_engine
	import i2c_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        scl,
	input  logic        scl_delay,
	input  logic        sda_in,
	output logic        sda_out,
	output logic        sda_out_en,
	input  i2c_byte_t   slave_addr,
	input  logic        start,
	input  logic        stop,
	output logic        stop_request,
	output i2c_status_t status,
	i2c_fifo_if.reader  tx,
	i2c_fifo_if.writer  rx
);

	i2c_state_e state;
	i2c_stream_e stream;
	logic [2:0] bit_cnt;
	i2c_byte_t shift_reg;
	logic start_pend;
	logic stop_pend;
	logic start_req;
	logic stop_req;
	logic mid_high;

	assign start_req = start | start_pend;
	assign stop_req = stop | stop_pend;
	assign mid_high = scl & scl_delay; // second half of scl high
	assign rx.push_data = shift_reg; // full byte sits here while push is high

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sda_out <= 1'b1;
			sda_out_en <= 1'b0;
			tx.pop <= 1'b0;
			rx.push <= 1'b0;
			stop_request <= 1'b0;
			status <= I2C_NO_ERR;
			state <= ST_IDLE;
			stream <= STREAM_NONE;
			bit_cnt <= '0;
			start_pend <= 1'b0;
			stop_pend <= 1'b0;
		end else begin
			tx.pop <= 1'b0;
			rx.push <= 1'b0;
			stop_request <= 1'b0;
			status <= I2C_NO_ERR;

			if (tx.pop) begin
				shift_reg <= tx.pop_data; // head advances after this clock
			end

			case (state)
				ST_START: begin
					if (mid_high) begin
						sda_out <= 1'b0; // sda falls while scl high
						shift_reg <= slave_addr;
						bit_cnt <= '0;
						stream <= STREAM_ADDR;
						state <= ST_OUT_ADDR;
					end
				end
				ST_STOP: begin
					if (mid_high) begin
						sda_out <= 1'b1;
						sda_out_en <= 1'b0;
						state <= ST_IDLE;
					end
				end
				ST_OUT_ADDR, ST_OUT_DATA: begin
					if (!scl) begin
						sda_out <= shift_reg[7]; // msb first
						shift_reg <= {shift_reg[6:0], 1'b0};
						sda_out_en <= 1'b1;
						state <= ST_DATA_LOOP;
					end
				end
				ST_CHECK_ADDR, ST_CHECK_OUT: begin
					if (!scl) begin
						sda_out_en <= 1'b0; // let target drive ack
						state <= ST_ACK;
					end
				end
				ST_IN_DATA: begin
					if (!scl) begin
						sda_out_en <= 1'b0;
						state <= ST_DATA_LOOP;
					end
				end
				ST_CHECK_IN: begin
					if (!scl) begin
						sda_out <= I2C_ACK;
						sda_out_en <= 1'b1;
						state <= ST_ACK;
					end
				end
				ST_DATA_LOOP: begin
					if (scl) begin
						bit_cnt <= bit_cnt + 1'b1;
						case (stream)
							STREAM_ADDR: begin
								state <= (bit_cnt == 3'd7) ? ST_CHECK_ADDR : ST_OUT_ADDR;
							end
							STREAM_RX: begin
								shift_reg <= {shift_reg[6:0], sda_in};
								if (bit_cnt == 3'd7) begin
									rx.push <= 1'b1;
									state <= ST_CHECK_IN;
								end else begin
									state <= ST_IN_DATA;
								end
							end
							STREAM_TX: begin
								state <= (bit_cnt == 3'd7) ? ST_CHECK_OUT : ST_OUT_DATA;
							end
							default: begin
								state <= ST_IDLE;
							end
						endcase
					end
				end
				ST_ACK: begin
					if (scl) begin
						if (stream == STREAM_RX) begin
							state <= ST_IN_DATA;
						end else if (sda_in != I2C_ACK) begin
							stop_request <= 1'b1;
							status <= (stream == STREAM_ADDR) ? I2C_ERR_NO_ADDR_ACK
								: I2C_ERR_NO_DATA_ACK;
							stream <= STREAM_NONE;
							state <= ST_IDLE;
						end else if (stream == STREAM_ADDR && slave_addr[0]) begin
							stream <= STREAM_RX; // read direction
							state <= ST_IN_DATA;
						end else if (tx.empty) begin
							stop_request <= 1'b1;
							status <= I2C_ERR_TX_EMPTY;
							stream <= STREAM_NONE;
							state <= ST_IDLE;
						end else begin
							tx.pop <= 1'b1;
							stream <= STREAM_TX;
							state <= ST_OUT_DATA;
						end
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase

			// bus conditions only set up while scl is low, strobes wait until then
			if (!scl && start_req) begin
				sda_out <= 1'b1;
				sda_out_en <= 1'b1;
				stream <= STREAM_NONE;
				state <= ST_START;
				start_pend <= 1'b0;
				stop_pend <= 1'b0;
			end else if (!scl && stop_req) begin
				sda_out <= 1'b0;
				sda_out_en <= 1'b1;
				stream <= STREAM_NONE;
				state <= ST_STOP;
				stop_pend <= 1'b0;
			end else begin
				if (start) begin
					start_pend <= 1'b1;
				end
				if (stop) begin
					stop_pend <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/i2c_master_top.sv
`default_nettype none

module i2c_master_top #(
	parameter int CLK_DIV = 8,
	parameter int FIFO_DEPTH = 4
) (
	input  logic       clk,
	input  logic       rst_n,
	output logic       scl,
	input  logic       sda_in,
	output logic       sda_out,
	output logic       sda_out_en,
	input  logic [7:0] slave_addr,
	input  logic       start,
	input  logic       stop,
	input  logic       tx_push,
	input  logic [7:0] tx_data,
	output logic       tx_full,
	input  logic       rx_pop,
	output logic [7:0] rx_data,
	output logic       rx_empty,
	output logic       stop_request,
	output logic [8:0] status
);

	logic scl_delay;

	i2c_fifo_if tx_if ();
	i2c_fifo_if rx_if ();

	// host side of both fifos
	assign tx_if.push = tx_push;
	assign tx_if.push_data = tx_data;
	assign tx_full = tx_if.full;
	assign rx_if.pop = rx_pop;
	assign rx_data = rx_if.pop_data;
	assign rx_empty = rx_if.empty;

	i2c_scl_timer #(
		.CLK_DIV(CLK_DIV)
	) u_scl_timer (
		.clk(clk),
		.rst_n(rst_n),
		.scl(scl),
		.scl_delay(scl_delay)
	);

	i2c_byte_engine u_byte_engine (
		.clk(clk),
		.rst_n(rst_n),
		.scl(scl),
		.scl_delay(scl_delay),
		.sda_in(sda_in),
		.sda_out(sda_out),
		.sda_out_en(sda_out_en),
		.slave_addr(slave_addr),
		.start(start),
		.stop(stop),
		.stop_request(stop_request),
		.status(status),
		.tx(tx_if),
		.rx(rx_if)
	);

	i2c_sync_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_tx_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.port(tx_if)
	);

	i2c_sync_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_rx_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.port(rx_if)
	);

endmodule

`default_nettype wire

//--- bench/i2c_slave_model.sv
`default_nettype none

module i2c_slave_model #(
	parameter logic [6:0] ADDR = 7'h2a
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       scl,
	input  logic       sda,
	input  logic [3:0] nack_index,
	output logic       sda_low
);

	typedef enum logic [2:0] {
		P_IDLE, P_ADDR, P_ADDR_ACK, P_WR, P_WR_ACK, P_RD, P_RD_ACK, P_IGNORE
	} phase_e;

	phase_e phase;
	logic scl_q;
	logic sda_q;
	logic ack_done;
	logic ack_ok;
	logic drive_low;
	logic [2:0] bit_cnt;
	logic [7:0] shreg;
	logic [7:0] addr_seen;
	logic [7:0] rd_mem [16];
	logic [7:0] wr_mem [16];
	int wr_count;
	int rd_idx;
	int stop_count;
	integer seed;

	initial begin
		seed = 32'h343c_27ae;
		for (int i = 0; i < 16; i++) begin
			rd_mem[i] = $random(seed);
		end
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			phase <= P_IDLE;
			scl_q <= 1'b1;
			sda_q <= 1'b1;
			ack_done <= 1'b0;
			drive_low <= 1'b0;
			bit_cnt <= '0;
			wr_count <= 0;
			rd_idx <= 0;
			stop_count <= 0;
		end else begin
			scl_q <= scl;
			sda_q <= sda;
			if (scl && scl_q && sda_q && !sda) begin // start condition
				phase <= P_ADDR;
				bit_cnt <= '0;
				wr_count <= 0;
				rd_idx <= 0;
				ack_done <= 1'b0;
				drive_low <= 1'b0;
			end else if (scl && scl_q && !sda_q && sda) begin // stop condition
				phase <= P_IDLE;
				drive_low <= 1'b0;
				stop_count <= stop_count + 1;
			end else if (scl && !scl_q) begin
				case (phase)
					P_ADDR, P_WR: begin
						shreg <= {shreg[6:0], sda};
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7 && phase == P_ADDR) begin
							addr_seen <= {shreg[6:0], sda};
							ack_ok <= (shreg[6:0] == ADDR);
							phase <= P_ADDR_ACK;
						end else if (bit_cnt == 3'd7) begin
							wr_mem[wr_count] <= {shreg[6:0], sda};
							ack_ok <= (wr_count != int'(nack_index));
							wr_count <= wr_count + 1;
							phase <= P_WR_ACK;
						end
					end
					P_RD: begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							rd_idx <= rd_idx + 1;
							phase <= P_RD_ACK;
						end
					end
					P_ADDR_ACK, P_WR_ACK, P_RD_ACK: ack_done <= 1'b1;
					default: ;
				endcase
			end else if (!scl && scl_q) begin
				case (phase)
					P_ADDR_ACK, P_WR_ACK: begin
						if (!ack_done) begin
							drive_low <= ack_ok; // ack slot
						end else if (!ack_ok) begin
							ack_done <= 1'b0;
							drive_low <= 1'b0;
							phase <= P_IGNORE;
						end else if (phase == P_ADDR_ACK && addr_seen[0]) begin
							ack_done <= 1'b0;
							drive_low <= ~rd_mem[rd_idx][7];
							phase <= P_RD;
						end else begin
							ack_done <= 1'b0;
							drive_low <= 1'b0;
							phase <= P_WR;
						end
					end
					P_RD_ACK: begin
						if (!ack_done) begin
							drive_low <= 1'b0; // master acks
						end else begin
							ack_done <= 1'b0;
							drive_low <= ~rd_mem[rd_idx][7];
							phase <= P_RD;
						end
					end
					P_RD: drive_low <= ~rd_mem[rd_idx][3'd7 - bit_cnt];
					default: drive_low <= 1'b0;
				endcase
			end
		end
	end

	always @(negedge clk) begin
		sda_low <= rst_n ? drive_low : 1'b0;
	end

endmodule

`default_nettype wire

//--- bench/tb_i2c_master.sv
`default_nettype none

module tb_i2c_master ();

	localparam int CLK_DIV = 8;
	localparam int FIFO_DEPTH = 4;
	localparam int TIMEOUT_CYCLES = 5000;
	localparam logic [7:0] WR_ADDR = 8'h54;
	localparam logic [7:0] RD_ADDR = 8'h55;
	localparam logic [7:0] BAD_ADDR = 8'h66;
	localparam logic [8:0] EXP_NO_ADDR_ACK = 9'h001;
	localparam logic [8:0] EXP_NO_DATA_ACK = 9'h002;
	localparam logic [8:0] EXP_TX_EMPTY = 9'h004;

	logic clk;
	logic rst_n;
	logic scl;
	logic sda_out;
	logic sda_out_en;
	wire sda_line;
	logic sda_low;
	logic [7:0] slave_addr;
	logic start;
	logic stop;
	logic tx_push;
	logic [7:0] tx_data;
	logic tx_full;
	logic rx_pop;
	logic [7:0] rx_data;
	logic rx_empty;
	logic stop_request;
	logic [8:0] status;
	logic [3:0] nack_index;
	logic reset_seen = 1'b0;
	logic started;
	logic sr_allowed;
	int min_wr;
	int run_cycles = 0;
	int sr_count = 0;
	logic [8:0] last_status;
	logic scl_q = 1'b1;
	logic sda_q = 1'b1;
	int high_cnt = 0;
	logic [7:0] wr_bytes [3] = '{8'h3c, 8'ha5, 8'h0f};

	// open-drain bus, either side can pull low
	assign sda_line = ~((sda_out_en & ~sda_out) | sda_low);

	i2c_master_top #(.CLK_DIV(CLK_DIV), .FIFO_DEPTH(FIFO_DEPTH)) u_i2c_master_top (
		.clk(clk), .rst_n(rst_n), .scl(scl), .sda_in(sda_line), .sda_out(sda_out),
		.sda_out_en(sda_out_en), .slave_addr(slave_addr), .start(start), .stop(stop),
		.tx_push(tx_push), .tx_data(tx_data), .tx_full(tx_full), .rx_pop(rx_pop),
		.rx_data(rx_data), .rx_empty(rx_empty), .stop_request(stop_request), .status(status)
	);

	i2c_slave_model u_slave (
		.clk(clk), .rst_n(rst_n), .scl(scl), .sda(sda_line),
		.nack_index(nack_index), .sda_low(sda_low)
	);

	always #10 clk = ~clk;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else report_failure(
			$sformatf("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	always @(posedge clk) begin
		run_cycles <= rst_n ? run_cycles + 1 : 0;
		if (!rst_n) reset_seen <= 1'b1;
		if (run_cycles >= TIMEOUT_CYCLES) report_failure("timeout: transfers did not complete");
		if (reset_seen) begin
			check_value("scl", scl, ((run_cycles / CLK_DIV) % 2 == 0)); // high first after reset
			if (!started) begin
				check_value("sda_out_en", sda_out_en, 1'b0);
				check_value("sda_out", sda_out, 1'b1);
				check_value("stop_request", stop_request, 1'b0);
			end
			if (!stop_request) check_value("status", status, 9'h000);
			if (stop_request) begin
				assert (sr_allowed) else report_failure("stop_request pulsed during a read");
				assert (u_slave.wr_count >= min_wr) else
					report_failure("stop_request came before all bytes were written");
				sr_count <= sr_count + 1;
				last_status <= status;
			end
		end
		if (rst_n) begin
			// sda may move during scl high only mid phase, as start or stop
			if (scl && scl_q && sda_line !== sda_q)
				assert (high_cnt >= CLK_DIV / 2) else report_failure("sda changed while scl high");
			high_cnt <= (scl && !scl_q) ? 1 : high_cnt + 1;
			scl_q <= scl;
			sda_q <= sda_line;
		end
	end

	task automatic push_tx(input logic [7:0] data);
		tx_push = 1'b1;
		tx_data = data;
		@(negedge clk);
		tx_push = 1'b0;
	endtask

	task automatic run_transfer(input logic [7:0] addr, input logic [8:0] exp_status);
		int n;
		int s;
		n = sr_count;
		s = u_slave.stop_count;
		started = 1'b1;
		slave_addr = addr;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		while (sr_count == n) @(negedge clk);
		check_value("status", last_status, exp_status);
		stop = 1'b1;
		@(negedge clk);
		stop = 1'b0;
		while (u_slave.stop_count == s) @(negedge clk);
	endtask

	initial begin
		int s;
		clk = 1'b0;
		rst_n = 1'b0;
		{slave_addr, start, stop, tx_push, tx_data, rx_pop} = '0;
		nack_index = 4'hf; // no data nack
		{started, sr_allowed, min_wr} = '0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		repeat (4 * CLK_DIV) @(negedge clk);

		for (int k = 0; k < 3; k++) push_tx(wr_bytes[k]);
		check_value("tx_full", tx_full, 1'b0);
		sr_allowed = 1'b1;
		min_wr = 3;
		run_transfer(WR_ADDR, EXP_TX_EMPTY);
		check_value("addr_seen", u_slave.addr_seen, WR_ADDR);
		check_value("wr_count", u_slave.wr_count, 3);
		for (int k = 0; k < 3; k++) check_value("wr_mem", u_slave.wr_mem[k], wr_bytes[k]);

		min_wr = 0;
		run_transfer(BAD_ADDR, EXP_NO_ADDR_ACK);
		check_value("addr_seen", u_slave.addr_seen, BAD_ADDR);
		check_value("wr_count", u_slave.wr_count, 0);

		nack_index = 4'd1;
		push_tx(wr_bytes[1]);
		push_tx(wr_bytes[2]);
		push_tx(wr_bytes[0]); // two spare bytes fill the fifo
		push_tx(wr_bytes[1]);
		check_value("tx_full", tx_full, 1'b1);
		min_wr = 2;
		run_transfer(WR_ADDR, EXP_NO_DATA_ACK);
		check_value("wr_count", u_slave.wr_count, 2);
		check_value("wr_mem", u_slave.wr_mem[0], wr_bytes[1]);
		check_value("wr_mem", u_slave.wr_mem[1], wr_bytes[2]);
		check_value("tx_full", tx_full, 1'b0);

		sr_allowed = 1'b0;
		s = u_slave.stop_count;
		slave_addr = RD_ADDR;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		for (int k = 0; k < 4; k++) begin
			while (rx_empty) @(negedge clk);
			check_value("rx_data", rx_data, u_slave.rd_mem[k]);
			rx_pop = 1'b1;
			@(negedge clk);
			rx_pop = 1'b0;
		end
		stop = 1'b1; // lands in the ack slot of the fourth byte
		@(negedge clk);
		stop = 1'b0;
		while (u_slave.stop_count == s) @(negedge clk);
		check_value("rx_empty", rx_empty, 1'b1);

		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
hw/i2c_pkg.sv
hw/i2c_fifo_if.sv
hw/i2c_scl_timer.sv
hw/i2c_sync_fifo.sv
hw/i2c_byte_engine.sv
hw/i2c_master_top.sv
bench/i2c_slave_model.sv
bench/tb_i2c_master.sv
